// File: Bender.yml
package:
  name: hyperbus_lite

sources:
  - include_dirs:
      - logic
    files:
      - logic/hyper_pkg.sv
      - logic/hyper_cmd_queue.sv
      - logic/hyper_wdata_queue.sv
      - logic/hyper_bus_seq.sv
      - logic/hyperbus_lite_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_clk_gen.sv
      - verification/hyper_mem_model.sv
      - verification/tb_hyperbus_lite.sv

// File: logic/hyper_bus_seq.sv
// HyperBus sequencer
// Runs CA, latency and data phases on the 8-bit bus
// and rebuilds read bytes into 16-bit words

`timescale 1ns/10ps
`include "hyper_defs.svh"

module hyper_bus_seq
    import hyper_pkg::*;
#(
    localparam int unsigned len_w    = $clog2(`HYPER_MAX_BURST + 1),
    localparam int unsigned wq_cnt_w = $clog2(`HYPER_WDATA_DEPTH + 1)
) (
    input  logic                clk_sys_i,
    input  logic                arst_n_i,

    // Command queue
    input  logic                ca_valid_i,
    input  hyper_ca_t           ca_word_i,
    input  logic [len_w-1:0]    ca_len_i,
    output logic                ca_pop_o,

    // Write-data queue
    input  logic [15:0]         wq_data_i,
    input  logic [wq_cnt_w-1:0] wq_count_i,
    output logic                wq_pop_o,

    // Bus
    output logic                hb_csn_o,
    output logic [7:0]          hb_dq_o,
    output logic                hb_dq_oe_o,
    input  logic [7:0]          hb_dq_i,
    input  logic                hb_rwds_i,

    // Read data to the host
    output logic                rdata_valid_o,
    output logic [15:0]         rdata_o
);

    localparam int unsigned cnt_w = $clog2(2 * `HYPER_MAX_BURST + `HYPER_LATENCY);

    typedef enum logic [2:0] {
        st_idle,
        st_ca,
        st_lat,
        st_wr,
        st_rd,
        st_csh
    } seq_state_e;

    seq_state_e       state_q;
    logic [cnt_w-1:0] cnt_q;
    hyper_ca_t        ca_q;
    logic [len_w-1:0] len_q;
    logic [15:0]      rd_word_q;
    logic             start;
    logic             last;

    // Writes wait until the full burst sits in the data queue
    assign start = (state_q == st_idle) && ca_valid_i &&
                   (ca_word_i.fields.rw || (wq_count_i >= wq_cnt_w'(ca_len_i)));
    assign last  = (cnt_q == '0);

    assign ca_pop_o = start;
    assign wq_pop_o = (state_q == st_wr) && !cnt_q[0];

    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= st_idle;
            cnt_q         <= '0;
            rdata_valid_o <= 1'b0;
        end else begin
            rdata_valid_o <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (start) begin
                        state_q <= st_ca;
                        cnt_q   <= cnt_w'(5);
                    end
                end
                st_ca: begin
                    if (!last) begin
                        cnt_q <= cnt_q - 1'b1;
                    end else if (ca_q.fields.rw) begin
                        state_q <= st_rd;
                        cnt_q   <= cnt_w'(2 * len_q - 1);
                    end else begin
                        state_q <= st_lat;
                        cnt_q   <= cnt_w'(`HYPER_LATENCY - 1);
                    end
                end
                st_lat: begin
                    if (last) begin
                        state_q <= st_wr;
                        cnt_q   <= cnt_w'(2 * len_q - 1);
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                st_wr: begin
                    if (last) begin
                        state_q <= st_csh;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                st_rd: begin
                    // Memory may stall with RWDS low, count only real bytes
                    if (hb_rwds_i) begin
                        rdata_valid_o <= !cnt_q[0];
                        if (last) begin
                            state_q <= st_csh;
                        end else begin
                            cnt_q <= cnt_q - 1'b1;
                        end
                    end
                end
                st_csh: begin
                    state_q <= st_idle;
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (start) begin
            ca_q  <= ca_word_i;
            len_q <= ca_len_i;
        end
        if ((state_q == st_rd) && hb_rwds_i) begin
            if (cnt_q[0]) begin
                rd_word_q[15:8] <= hb_dq_i;
            end else begin
                rd_word_q[7:0] <= hb_dq_i;
            end
        end
    end

    assign rdata_o = rd_word_q;

    assign hb_csn_o   = (state_q == st_idle) || (state_q == st_csh);
    assign hb_dq_oe_o = (state_q == st_ca) || (state_q == st_wr);

    // Odd count is the upper byte of a word
    always_comb begin
        case (state_q)
            st_ca:   hb_dq_o = ca_q.bytes[cnt_q[2:0]];
            st_wr:   hb_dq_o = cnt_q[0] ? wq_data_i[15:8] : wq_data_i[7:0];
            default: hb_dq_o = 8'h00;
        endcase
    end

    assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        hb_dq_oe_o |-> !hb_csn_o);

    // A word leaves the queue on its lower byte, after the upper byte went out
    assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        wq_pop_o |-> (state_q == st_wr) && ($past(state_q) == st_wr));

endmodule : hyper_bus_seq

// File: logic/hyper_cmd_queue.sv
// HyperBus command queue
// Credit-controlled FIFO that packs each host request into a CA word

`timescale 1ns/10ps
`include "hyper_defs.svh"

module hyper_cmd_queue
    import hyper_pkg::*;
#(
    localparam int unsigned len_w = $clog2(`HYPER_MAX_BURST + 1)
) (
    input  logic                     clk_sys_i,
    input  logic                     arst_n_i,

    input  logic                     cmd_valid_i,
    input  logic                     cmd_write_i,
    input  logic [`HYPER_ADDR_W-1:0] cmd_addr_i,
    input  logic [len_w-1:0]         cmd_len_i,
    output logic                     cmd_credit_o,

    input  logic                     ca_pop_i,
    output logic                     ca_valid_o,
    output hyper_ca_t                ca_word_o,
    output logic [len_w-1:0]         ca_len_o
);

    localparam int unsigned ptr_w = $clog2(`HYPER_CMD_DEPTH);
    localparam int unsigned cnt_w = $clog2(`HYPER_CMD_DEPTH + 1);

    hyper_ca_t        ca_mem  [`HYPER_CMD_DEPTH];
    logic [len_w-1:0] len_mem [`HYPER_CMD_DEPTH];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;
    hyper_ca_t        ca_new;

    always_comb begin
        ca_new                = '0;
        ca_new.fields.rw      = ~cmd_write_i;
        ca_new.fields.space   = 1'b0;
        ca_new.fields.burst   = 1'b1;
        ca_new.fields.addr_hi = cmd_addr_i[`HYPER_ADDR_W-1:3];
        ca_new.fields.addr_lo = cmd_addr_i[2:0];
    end

    always_ff @(posedge clk_sys_i) begin
        if (cmd_valid_i) begin
            ca_mem[wr_ptr_q]  <= ca_new;
            len_mem[wr_ptr_q] <= cmd_len_i;
        end
    end

    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            count_q      <= '0;
            cmd_credit_o <= 1'b0;
        end else begin
            // Credit goes back one cycle after the entry leaves
            cmd_credit_o <= ca_pop_i;
            if (cmd_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == ptr_w'(`HYPER_CMD_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (ca_pop_i) begin
                rd_ptr_q <= (rd_ptr_q == ptr_w'(`HYPER_CMD_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({cmd_valid_i, ca_pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign ca_valid_o = (count_q != '0);
    assign ca_word_o  = ca_mem[rd_ptr_q];
    assign ca_len_o   = len_mem[rd_ptr_q];

    // Host must hold a credit, so a push never meets a full queue
    assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        cmd_valid_i |-> count_q < cnt_w'(`HYPER_CMD_DEPTH));

    assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        cmd_valid_i |-> (cmd_len_i >= 1) && (cmd_len_i <= len_w'(`HYPER_MAX_BURST)));

endmodule : hyper_cmd_queue

// File: logic/hyper_defs.svh
// HyperBus controller parameters
// Queue depths, bus latency, burst limit and address width

`ifndef HYPER_DEFS_SVH
`define HYPER_DEFS_SVH

// Command FIFO entries, also the initial command credits
`define HYPER_CMD_DEPTH   4

// Write-data FIFO entries, also the initial data credits
`define HYPER_WDATA_DEPTH 16

// Idle cycles between last CA byte and first write byte
`define HYPER_LATENCY     6

// Longest burst in 16-bit words
`define HYPER_MAX_BURST   8

`define HYPER_ADDR_W      32

`endif

// File: logic/hyper_pkg.sv
// HyperBus controller types
// Command-address word, seen as fields or as six bus bytes

package hyper_pkg;

    // MSB first, matches the order of bits on the bus
    typedef struct packed {
        logic        rw;       // 1 for read
        logic        space;    // 0 selects memory
        logic        burst;    // 1 selects linear
        logic [28:0] addr_hi;
        logic [12:0] rsvd;
        logic [2:0]  addr_lo;
    } hyper_ca_fields_t;

    // Byte 5 leaves first
    typedef union packed {
        hyper_ca_fields_t fields;
        logic [5:0][7:0]  bytes;
    } hyper_ca_t;

endpackage : hyper_pkg

// File: logic/hyper_wdata_queue.sv
// HyperBus write-data queue
// Credit-controlled FIFO of 16-bit words, occupancy shown to the sequencer

`timescale 1ns/10ps
`include "hyper_defs.svh"

module hyper_wdata_queue #(
    localparam int unsigned cnt_w = $clog2(`HYPER_WDATA_DEPTH + 1)
) (
    input  logic             clk_sys_i,
    input  logic             arst_n_i,

    input  logic             wdata_valid_i,
    input  logic [15:0]      wdata_i,
    output logic             wdata_credit_o,

    input  logic             wq_pop_i,
    output logic [15:0]      wq_data_o,
    output logic [cnt_w-1:0] wq_count_o
);

    localparam int unsigned ptr_w = $clog2(`HYPER_WDATA_DEPTH);

    logic [15:0]      data_mem [`HYPER_WDATA_DEPTH];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] count_q;

    always_ff @(posedge clk_sys_i) begin
        if (wdata_valid_i) begin
            data_mem[wr_ptr_q] <= wdata_i;
        end
    end

    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q       <= '0;
            rd_ptr_q       <= '0;
            count_q        <= '0;
            wdata_credit_o <= 1'b0;
        end else begin
            wdata_credit_o <= wq_pop_i;
            if (wdata_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == ptr_w'(`HYPER_WDATA_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (wq_pop_i) begin
                rd_ptr_q <= (rd_ptr_q == ptr_w'(`HYPER_WDATA_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({wdata_valid_i, wq_pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign wq_data_o  = data_mem[rd_ptr_q];
    assign wq_count_o = count_q;

    assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        wdata_valid_i |-> count_q < cnt_w'(`HYPER_WDATA_DEPTH));

    // Sequencer only starts a write once the whole burst is here
    assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        wq_pop_i |-> count_q != '0);

endmodule : hyper_wdata_queue

// File: logic/hyperbus_lite_top.sv
// HyperBus lite controller
// Command and write-data queues feeding one bus sequencer

`timescale 1ns/10ps
`include "hyper_defs.svh"

module hyperbus_lite_top
    import hyper_pkg::*;
#(
    localparam int unsigned len_w    = $clog2(`HYPER_MAX_BURST + 1),
    localparam int unsigned wq_cnt_w = $clog2(`HYPER_WDATA_DEPTH + 1)
) (
    input  logic                     clk_sys_i,
    input  logic                     arst_n_i,

    // Host commands
    input  logic                     cmd_valid_i,
    input  logic                     cmd_write_i,
    input  logic [`HYPER_ADDR_W-1:0] cmd_addr_i,
    input  logic [len_w-1:0]         cmd_len_i,
    output logic                     cmd_credit_o,

    // Host write data
    input  logic                     wdata_valid_i,
    input  logic [15:0]              wdata_i,
    output logic                     wdata_credit_o,

    // Host read data
    output logic                     rdata_valid_o,
    output logic [15:0]              rdata_o,

    // HyperBus
    output logic                     hb_csn_o,
    output logic [7:0]               hb_dq_o,
    output logic                     hb_dq_oe_o,
    input  logic [7:0]               hb_dq_i,
    input  logic                     hb_rwds_i
);

    logic                ca_valid;
    hyper_ca_t           ca_word;
    logic [len_w-1:0]    ca_len;
    logic                ca_pop;
    logic [15:0]         wq_data;
    logic [wq_cnt_w-1:0] wq_count;
    logic                wq_pop;

    hyper_cmd_queue i_cmd_queue (
        .clk_sys_i    ( clk_sys_i    ),
        .arst_n_i     ( arst_n_i     ),
        .cmd_valid_i  ( cmd_valid_i  ),
        .cmd_write_i  ( cmd_write_i  ),
        .cmd_addr_i   ( cmd_addr_i   ),
        .cmd_len_i    ( cmd_len_i    ),
        .ca_pop_i     ( ca_pop       ),
        .cmd_credit_o ( cmd_credit_o ),
        .ca_valid_o   ( ca_valid     ),
        .ca_word_o    ( ca_word      ),
        .ca_len_o     ( ca_len       )
    );

    hyper_wdata_queue i_wdata_queue (
        .clk_sys_i      ( clk_sys_i      ),
        .arst_n_i       ( arst_n_i       ),
        .wdata_valid_i  ( wdata_valid_i  ),
        .wdata_i        ( wdata_i        ),
        .wq_pop_i       ( wq_pop         ),
        .wdata_credit_o ( wdata_credit_o ),
        .wq_data_o      ( wq_data        ),
        .wq_count_o     ( wq_count       )
    );

    hyper_bus_seq i_bus_seq (
        .clk_sys_i     ( clk_sys_i     ),
        .arst_n_i      ( arst_n_i      ),
        .ca_valid_i    ( ca_valid      ),
        .ca_word_i     ( ca_word       ),
        .ca_len_i      ( ca_len        ),
        .ca_pop_o      ( ca_pop        ),
        .wq_data_i     ( wq_data       ),
        .wq_count_i    ( wq_count      ),
        .wq_pop_o      ( wq_pop        ),
        .hb_csn_o      ( hb_csn_o      ),
        .hb_dq_o       ( hb_dq_o       ),
        .hb_dq_oe_o    ( hb_dq_oe_o    ),
        .hb_dq_i       ( hb_dq_i       ),
        .hb_rwds_i     ( hb_rwds_i     ),
        .rdata_valid_o ( rdata_valid_o ),
        .rdata_o       ( rdata_o       )
    );

endmodule : hyperbus_lite_top

// File: sim.f
+incdir+logic
logic/hyper_pkg.sv
logic/hyper_cmd_queue.sv
logic/hyper_wdata_queue.sv
logic/hyper_bus_seq.sv
logic/hyperbus_lite_top.sv
verification/tb_clk_gen.sv
verification/hyper_mem_model.sv
verification/tb_hyperbus_lite.sv

// File: verification/hyper_mem_model.sv
// Behavioural HyperRAM for simulation
// Decodes CA bytes, stores write bytes and answers reads with RWDS
// 256 words, upper address bits alias onto them

`timescale 1ns/10ps
`include "hyper_defs.svh"

module hyper_mem_model (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       hb_csn_i,
    input  logic [7:0] hb_dq_i,
    input  logic       hb_dq_oe_i,
    output logic [7:0] hb_dq_o,
    output logic       hb_rwds_o
);

    logic [15:0] mem [256];
    logic [47:0] ca_sr;
    logic [7:0]  word_idx;
    int unsigned idx;
    int unsigned byte_cnt;
    logic        hold;

    // Last decoded command
    logic [47:0] last_ca;
    logic        last_read;
    logic [31:0] last_addr;

    initial begin
        hb_dq_o   = 8'h00;
        hb_rwds_o = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0]};
        end
    end

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i || hb_csn_i) begin
            idx       = 0;
            byte_cnt  = 0;
            hold      = 1'b0;
            hb_dq_o   <= 8'h00;
            hb_rwds_o <= 1'b0;
        end else begin
            if (idx < 6) begin
                ca_sr = {ca_sr[39:0], hb_dq_i};
                if (idx == 5) begin
                    last_ca   = ca_sr;
                    last_read = ca_sr[47];
                    last_addr = {ca_sr[44:16], ca_sr[2:0]};
                end
            end else if (last_read) begin
                // Driven here, seen by the controller one cycle later
                if (idx >= 5 + `HYPER_LATENCY) begin
                    if (hold) begin
                        hold      = 1'b0;
                        hb_rwds_o <= 1'b0;
                    end else begin
                        word_idx  = 8'(last_addr + byte_cnt / 2);
                        hb_dq_o   <= byte_cnt[0] ? mem[word_idx][7:0] : mem[word_idx][15:8];
                        hb_rwds_o <= 1'b1;
                        byte_cnt  = byte_cnt + 1;
                        // Stall after every third byte
                        hold      = (byte_cnt % 3 == 0);
                    end
                end
            end else if (hb_dq_oe_i && (idx >= 6 + `HYPER_LATENCY)) begin
                word_idx = 8'(last_addr + byte_cnt / 2);
                if (byte_cnt[0]) begin
                    mem[word_idx][7:0] = hb_dq_i;
                end else begin
                    mem[word_idx][15:8] = hb_dq_i;
                end
                byte_cnt = byte_cnt + 1;
            end
            idx = idx + 1;
        end
    end

endmodule : hyper_mem_model

// File: verification/tb_clk_gen.sv
// Testbench clock and reset
// 100 ns clock, reset held low for the first 8 rising edges

`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_sys_o,
    output logic arst_n_o
);

    initial begin
        clk_sys_o = 1'b0;
        forever begin
            #50 clk_sys_o = ~clk_sys_o;
        end
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(posedge clk_sys_o);
        #1 arst_n_o = 1'b1;
    end

endmodule : tb_clk_gen

// File: verification/tb_hyperbus_lite.sv
// HyperBus lite controller testbench
// Directed and random traffic against a HyperRAM model,
// read words checked against a reference word array

`timescale 1ns/10ps
`include "hyper_defs.svh"

module tb_hyperbus_lite;

    // Transactions issued by all tests together
    localparam int unsigned n_txn       = 50;
    localparam int unsigned cycle_limit = 40 * n_txn + 200;

    logic        clk_sys;
    logic        arst_n;
    logic        cmd_valid;
    logic        cmd_write;
    logic [31:0] cmd_addr;
    logic [3:0]  cmd_len;
    logic        cmd_credit;
    logic        wdata_valid;
    logic [15:0] wdata;
    logic        wdata_credit;
    logic        rdata_valid;
    logic [15:0] rdata;
    logic        hb_csn;
    logic [7:0]  dq_to_mem;
    logic        hb_dq_oe;
    logic [7:0]  dq_from_mem;
    logic        hb_rwds;

    logic [31:0] lfsr_q;
    logic [15:0] ref_mem [256];
    logic [15:0] exp_q [$];
    logic        csn_prev = 1'b1;

    int unsigned cmd_credits   = `HYPER_CMD_DEPTH;
    int unsigned wdata_credits = `HYPER_WDATA_DEPTH;
    int unsigned cmd_pushes;
    int unsigned cmd_returns;
    int unsigned wdata_pushes;
    int unsigned wdata_returns;
    int unsigned bus_done;
    int unsigned check_count;
    int unsigned err_count;
    int unsigned test_count;
    int unsigned cycle_count;

    tb_clk_gen clk_gen0 (
        .clk_sys_o ( clk_sys ),
        .arst_n_o  ( arst_n  )
    );

    hyperbus_lite_top dut0 (
        .clk_sys_i      ( clk_sys      ),
        .arst_n_i       ( arst_n       ),
        .cmd_valid_i    ( cmd_valid    ),
        .cmd_write_i    ( cmd_write    ),
        .cmd_addr_i     ( cmd_addr     ),
        .cmd_len_i      ( cmd_len      ),
        .cmd_credit_o   ( cmd_credit   ),
        .wdata_valid_i  ( wdata_valid  ),
        .wdata_i        ( wdata        ),
        .wdata_credit_o ( wdata_credit ),
        .rdata_valid_o  ( rdata_valid  ),
        .rdata_o        ( rdata        ),
        .hb_csn_o       ( hb_csn       ),
        .hb_dq_o        ( dq_to_mem    ),
        .hb_dq_oe_o     ( hb_dq_oe     ),
        .hb_dq_i        ( dq_from_mem  ),
        .hb_rwds_i      ( hb_rwds      )
    );

    hyper_mem_model mem0 (
        .clk_i      ( clk_sys     ),
        .arst_n_i   ( arst_n      ),
        .hb_csn_i   ( hb_csn      ),
        .hb_dq_i    ( dq_to_mem   ),
        .hb_dq_oe_i ( hb_dq_oe    ),
        .hb_dq_o    ( dq_from_mem ),
        .hb_rwds_o  ( hb_rwds     )
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] expected_word(input logic [31:0] addr);
        return ref_mem[addr[7:0]];
    endfunction

    // rw, space, burst, addr[31:3], 13 reserved zeros, addr[2:0]
    function automatic logic [47:0] ca_expected(input logic write, input logic [31:0] addr);
        return {~write, 1'b0, 1'b1, addr[31:3], 13'h0000, addr[2:0]};
    endfunction

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] want);
        check_count++;
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
            err_count++;
        end
    endtask

    task automatic push_cmd(input logic wr, input logic [31:0] addr, input int unsigned len);
        while (cmd_credits == 0) begin
            @(posedge clk_sys);
            #1;
        end
        cmd_valid = 1'b1;
        cmd_write = wr;
        cmd_addr  = addr;
        cmd_len   = 4'(len);
        @(posedge clk_sys);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic push_wdata(input logic [15:0] word);
        while (wdata_credits == 0) begin
            @(posedge clk_sys);
            #1;
        end
        wdata_valid = 1'b1;
        wdata       = word;
        @(posedge clk_sys);
        #1;
        wdata_valid = 1'b0;
    endtask

    task automatic issue_write(input logic [31:0] addr, input int unsigned len);
        logic [15:0] w;
        push_cmd(1'b1, addr, len);
        for (int i = 0; i < len; i++) begin
            w = rand_bits(16);
            ref_mem[8'(addr + i)] = w;
            push_wdata(w);
        end
    endtask

    task automatic issue_read(input logic [31:0] addr, input int unsigned len);
        for (int i = 0; i < len; i++) begin
            exp_q.push_back(expected_word(addr + i));
        end
        push_cmd(1'b0, addr, len);
    endtask

    // All reads answered and every command finished on the bus
    task automatic wait_idle();
        while (exp_q.size() != 0 || bus_done != cmd_pushes) begin
            @(posedge clk_sys);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int unsigned errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %-16s passed", name);
        end else begin
            $display("test %-16s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    always @(negedge clk_sys) begin
        if (arst_n) begin
            if (cmd_valid) begin
                cmd_pushes++;
                cmd_credits--;
            end
            if (cmd_credit) begin
                cmd_returns++;
                cmd_credits++;
            end
            if (wdata_valid) begin
                wdata_pushes++;
                wdata_credits--;
            end
            if (wdata_credit) begin
                wdata_returns++;
                wdata_credits++;
            end
            if (cmd_credits > `HYPER_CMD_DEPTH) begin
                $display("Command credit count rose above the queue depth");
                err_count++;
            end
            if (wdata_credits > `HYPER_WDATA_DEPTH) begin
                $display("Write data credit count rose above the queue depth");
                err_count++;
            end
        end
    end

    // Chip select rising ends one bus transaction
    always @(negedge clk_sys) begin
        if (arst_n && hb_csn && !csn_prev) begin
            bus_done++;
        end
        csn_prev = hb_csn;
    end

    always @(negedge clk_sys) begin
        if (arst_n && rdata_valid) begin
            if (exp_q.size() == 0) begin
                $display("Read word 0x%04h arrived with no read outstanding", rdata);
                err_count++;
            end else begin
                check_value("rdata_o", rdata, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk_sys) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, traffic did not complete", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] addr;
        int unsigned len;
        int unsigned errs_before;

        cmd_valid   = 1'b0;
        cmd_write   = 1'b0;
        cmd_addr    = '0;
        cmd_len     = '0;
        wdata_valid = 1'b0;
        wdata       = '0;
        lfsr_q      = 32'hf59;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = {i[7:0], ~i[7:0]};
        end

        errs_before = err_count;
        @(negedge clk_sys);
        check_value("hb_csn_o", hb_csn, 1);
        check_value("hb_dq_oe_o", hb_dq_oe, 0);
        check_value("rdata_valid_o", rdata_valid, 0);
        wait (arst_n === 1'b1);
        repeat (4) @(negedge clk_sys);
        check_value("hb_csn_o", hb_csn, 1);
        check_value("hb_dq_oe_o", hb_dq_oe, 0);
        check_value("rdata_valid_o", rdata_valid, 0);
        check_value("cmd_credit_o pulses", cmd_returns, 0);
        check_value("wdata_credit_o pulses", wdata_returns, 0);
        @(posedge clk_sys);
        #1;
        report_test("reset_state", errs_before);

        errs_before = err_count;
        addr = rand_bits(32);
        issue_write(addr, 1);
        issue_read(addr, 1);
        wait_idle();
        report_test("single_word", errs_before);

        errs_before = err_count;
        addr = rand_bits(32);
        len  = rand_bits(3) + 1;
        issue_write(addr, len);
        wait_idle();
        check_value("CA of write", mem0.last_ca, ca_expected(1'b1, addr));
        addr = rand_bits(32);
        len  = rand_bits(3) + 1;
        issue_read(addr, len);
        wait_idle();
        check_value("CA of read", mem0.last_ca, ca_expected(1'b0, addr));
        report_test("ca_layout", errs_before);

        errs_before = err_count;
        for (int l = 1; l <= `HYPER_MAX_BURST; l++) begin
            addr = rand_bits(32);
            issue_write(addr, l);
            issue_read(addr, l);
        end
        wait_idle();
        report_test("burst_lengths", errs_before);

        // Back to back, limited only by credits
        errs_before = err_count;
        for (int n = 0; n < 30; n++) begin
            addr = rand_bits(32);
            len  = rand_bits(3) + 1;
            if (rand_bits(1)) begin
                issue_write(addr, len);
            end else begin
                issue_read(addr, len);
            end
        end
        wait_idle();
        report_test("random_traffic", errs_before);

        errs_before = err_count;
        check_value("cmd_credit_o pulses", cmd_returns, cmd_pushes);
        check_value("wdata_credit_o pulses", wdata_returns, wdata_pushes);
        report_test("credit_balance", errs_before);

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_hyperbus_lite
